/* common/spu_decode_settings.svh */
`ifndef SPU_DECODE_SETTINGS_SVH
`define SPU_DECODE_SETTINGS_SVH

`define SPU_INSTR_W 32        // one fetched word
`define SPU_OP_W 11           // opcode, right aligned
`define SPU_REG_W 7           // 128 registers
`define SPU_IMM_W 18          // widest immediate (ri18)
`define SPU_FMT_W 3
`define SPU_UNIT_W 2
`define SPU_PC_W 8

`define SPU_FMT_RR 3'd0
`define SPU_FMT_RRR 3'd1
`define SPU_FMT_RI7 3'd2
`define SPU_FMT_RI8 3'd3
`define SPU_FMT_RI10 3'd4
`define SPU_FMT_RI16 3'd5
`define SPU_FMT_RI18 3'd6

`define SPU_UNIT_FP 2'd0      // even pipe units
`define SPU_UNIT_FX2 2'd1
`define SPU_UNIT_BYTE 2'd2
`define SPU_UNIT_FX1 2'd3
`define SPU_UNIT_PERM 2'd0    // odd pipe units
`define SPU_UNIT_LS 2'd1
`define SPU_UNIT_BR 2'd2

`endif

/* common/spu_opcodes.svh */
`ifndef SPU_OPCODES_SVH
`define SPU_OPCODES_SVH

// even pipe, rrr
`define SPU_OP_MPYA 4'b1100
`define SPU_OP_FMA 4'b1110
`define SPU_OP_FMS 4'b1111
// even pipe, ri18 / ri8 / ri16
`define SPU_OP_ILA 7'b0100001
`define SPU_OP_CFLTS 10'b0111011000
`define SPU_OP_CFLTU 10'b0111011001
`define SPU_OP_ILH 9'b010000011
`define SPU_OP_ILHU 9'b010000010
`define SPU_OP_IOHL 9'b011000001
// even pipe, ri10
`define SPU_OP_MPYI 8'b01110100
`define SPU_OP_MPYUI 8'b01110101
`define SPU_OP_AHI 8'b00011101
`define SPU_OP_AI 8'b00011100
`define SPU_OP_SFHI 8'b00001101
`define SPU_OP_SFI 8'b00001100
`define SPU_OP_ANDBI 8'b00010110
`define SPU_OP_ANDHI 8'b00010101
`define SPU_OP_ANDI 8'b00010100
`define SPU_OP_ORBI 8'b00000110
`define SPU_OP_ORHI 8'b00000101
`define SPU_OP_ORI 8'b00000100
`define SPU_OP_XORBI 8'b01000110
`define SPU_OP_XORHI 8'b01000101
`define SPU_OP_XORI 8'b01000100
`define SPU_OP_CEQBI 8'b01111110
`define SPU_OP_CEQHI 8'b01111101
`define SPU_OP_CEQI 8'b01111100
`define SPU_OP_CGTBI 8'b01001110
`define SPU_OP_CGTHI 8'b01001101
`define SPU_OP_CGTI 8'b01001100
`define SPU_OP_CLGTBI 8'b01011110
`define SPU_OP_CLGTHI 8'b01011101
`define SPU_OP_CLGTI 8'b01011100
// even pipe, rr
`define SPU_OP_MPY 11'b01111000100
`define SPU_OP_MPYU 11'b01111001100
`define SPU_OP_MPYH 11'b01111000101
`define SPU_OP_FA 11'b01011000100
`define SPU_OP_FS 11'b01011000101
`define SPU_OP_FM 11'b01011000110
`define SPU_OP_FCEQ 11'b01111000010
`define SPU_OP_FCGT 11'b01011000010
`define SPU_OP_SHLH 11'b00001011111
`define SPU_OP_SHL 11'b00001011011
`define SPU_OP_ROTH 11'b00001011100
`define SPU_OP_ROT 11'b00001011000
`define SPU_OP_ROTHM 11'b00001011101
`define SPU_OP_ROTM 11'b00001011001
`define SPU_OP_ROTMAH 11'b00001011110
`define SPU_OP_ROTMA 11'b00001011010
`define SPU_OP_CNTB 11'b01010110100
`define SPU_OP_AVGB 11'b00011010011
`define SPU_OP_ABSDB 11'b00001010011
`define SPU_OP_SUMB 11'b01001010011
`define SPU_OP_AH 11'b00011001000
`define SPU_OP_A 11'b00011000000
`define SPU_OP_SFH 11'b00001001000
`define SPU_OP_SF 11'b00001000000
`define SPU_OP_AND 11'b00011000001
`define SPU_OP_OR 11'b00001000001
`define SPU_OP_XOR 11'b01001000001
`define SPU_OP_NAND 11'b00011001001
`define SPU_OP_CEQB 11'b01111010000
`define SPU_OP_CEQH 11'b01111001000
`define SPU_OP_CEQ 11'b01111000000
`define SPU_OP_CGTB 11'b01001010000
`define SPU_OP_CGTH 11'b01001001000
`define SPU_OP_CGT 11'b01001000000
`define SPU_OP_CLGTB 11'b01011010000
`define SPU_OP_CLGTH 11'b01011001000
`define SPU_OP_CLGT 11'b01011000000
`define SPU_OP_NOP 11'b01000000001      // even nop, no write
// even pipe, ri7
`define SPU_OP_SHLI 11'b00001111011
`define SPU_OP_ROTHI 11'b00001111100
`define SPU_OP_ROTI 11'b00001111000
`define SPU_OP_ROTMAHI 11'b00001111110
`define SPU_OP_ROTMAI 11'b00001111010
// odd pipe, ri10 / ri16
`define SPU_OP_LQD 8'b00110100
`define SPU_OP_STQD 8'b00100100         // own code, not lqd's
`define SPU_OP_LQA 9'b001100001
`define SPU_OP_STQA 9'b001000001
`define SPU_OP_BR 9'b001100100
`define SPU_OP_BRA 9'b001100000
`define SPU_OP_BRSL 9'b001100110
`define SPU_OP_BRNZ 9'b001000010
`define SPU_OP_BRZ 9'b001000000
// odd pipe, rr
`define SPU_OP_SHLQBI 11'b00111011011
`define SPU_OP_SHLQBY 11'b00111011111
`define SPU_OP_ROTQBI 11'b00111011000
`define SPU_OP_ROTQBY 11'b00111011100
`define SPU_OP_GBB 11'b00110110010
`define SPU_OP_GBH 11'b00110110001
`define SPU_OP_GB 11'b00110110000
`define SPU_OP_LQX 11'b00111000100
`define SPU_OP_STQX 11'b00101000100
`define SPU_OP_BI 11'b00110101000
`define SPU_OP_LNOP 11'b00000000001
// odd pipe, ri7
`define SPU_OP_SHLQBII 11'b00111111011
`define SPU_OP_SHLQBYI 11'b00111111111
`define SPU_OP_ROTQBII 11'b00111111000
`define SPU_OP_ROTQBYI 11'b00111111100

`endif

/* common/spu_decode_pkg.sv */
`default_nettype none
`include "spu_decode_settings.svh"

package spu_decode_pkg;

	typedef union packed {
		struct packed {
			logic [`SPU_OP_W-1:0]  op;     // full 11-bit opcode
			logic [`SPU_REG_W-1:0] rb;
			logic [`SPU_REG_W-1:0] ra;
			logic [`SPU_REG_W-1:0] rt;     // low bits, all formats but rrr
		} rr;
		struct packed {
			logic [3:0]            op;
			logic [`SPU_REG_W-1:0] rt;     // target right after opcode
			logic [`SPU_REG_W-1:0] rb;
			logic [`SPU_REG_W-1:0] ra;
			logic [`SPU_REG_W-1:0] rc;
		} rrr;
		logic [`SPU_INSTR_W-1:0] ri;       // raw bits for ri prefixes/immediates
	} instr_word_u;

	// opcode of a matched word, zero padded on the left
	function automatic logic [`SPU_OP_W-1:0] op_field(instr_word_u w, logic [`SPU_FMT_W-1:0] fmt);
		case (fmt)
			`SPU_FMT_RRR: op_field = {7'd0, w.rrr.op};
			`SPU_FMT_RI18: op_field = {4'd0, w.ri[31:25]};
			`SPU_FMT_RI8: op_field = {1'd0, w.ri[31:22]};
			`SPU_FMT_RI16: op_field = {2'd0, w.ri[31:23]};
			`SPU_FMT_RI10: op_field = {3'd0, w.ri[31:24]};
			default: op_field = w.rr.op;   // rr and ri7 use all 11 bits
		endcase
	endfunction

	// immediate per format, sign extended to 18 bits
	function automatic logic [`SPU_IMM_W-1:0] imm_field(instr_word_u w, logic [`SPU_FMT_W-1:0] fmt);
		case (fmt)
			`SPU_FMT_RI18: imm_field = w.ri[24:7];
			`SPU_FMT_RI16: imm_field = {{2{w.ri[22]}}, w.ri[22:7]};
			`SPU_FMT_RI10: imm_field = {{8{w.ri[23]}}, w.ri[23:14]};
			`SPU_FMT_RI8: imm_field = {{10{w.ri[21]}}, w.ri[21:14]};
			`SPU_FMT_RI7: imm_field = {{11{w.ri[20]}}, w.ri[20:14]};
			default: imm_field = '0;       // rr/rrr carry none
		endcase
	endfunction

endpackage

`default_nettype wire

/* decode/even_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spu_decode_settings.svh"
`include "spu_opcodes.svh"

module even_decoder
	import spu_decode_pkg::*;
(
	input  instr_word_u             word,
	output logic                    hit,
	output logic [`SPU_OP_W-1:0]    op,
	output logic [`SPU_FMT_W-1:0]   format,
	output logic [`SPU_UNIT_W-1:0]  unit,
	output logic [`SPU_REG_W-1:0]   rt,
	output logic [`SPU_IMM_W-1:0]   imm,
	output logic                    reg_write
);

	logic [6:0]              p7;    // ri18 prefix
	logic [7:0]              p8;    // ri10 prefix
	logic [8:0]              p9;    // ri16 prefix
	logic [9:0]              p10;   // ri8 prefix
	logic [`SPU_FMT_W-1:0]   fmt;
	logic [`SPU_UNIT_W-1:0]  unt;
	logic                    wr;

	assign p7 = word.ri[31:25];
	assign p8 = word.ri[31:24];
	assign p9 = word.ri[31:23];
	assign p10 = word.ri[31:22];

	// prefix match in table priority order
	always_comb begin
		hit = 1'b1;
		fmt = `SPU_FMT_RR;
		unt = `SPU_UNIT_FP;
		wr = 1'b1;
		if (word.rrr.op inside {`SPU_OP_MPYA, `SPU_OP_FMA, `SPU_OP_FMS}) begin
			fmt = `SPU_FMT_RRR;                    // fused multiply ops
		end else if (p7 == `SPU_OP_ILA) begin
			fmt = `SPU_FMT_RI18;
			unt = `SPU_UNIT_FX1;
		end else if (p10 inside {`SPU_OP_CFLTS, `SPU_OP_CFLTU}) begin
			fmt = `SPU_FMT_RI8;                    // float convert on the fp unit
		end else if (p9 inside {`SPU_OP_ILH, `SPU_OP_ILHU, `SPU_OP_IOHL}) begin
			fmt = `SPU_FMT_RI16;
			unt = `SPU_UNIT_FX1;
		end else if (p8 inside {`SPU_OP_MPYI, `SPU_OP_MPYUI}) begin
			fmt = `SPU_FMT_RI10;
		end else if (p8 inside {`SPU_OP_AHI, `SPU_OP_AI, `SPU_OP_SFHI, `SPU_OP_SFI,
				`SPU_OP_ANDBI, `SPU_OP_ANDHI, `SPU_OP_ANDI, `SPU_OP_ORBI,
				`SPU_OP_ORHI, `SPU_OP_ORI, `SPU_OP_XORBI, `SPU_OP_XORHI,
				`SPU_OP_XORI, `SPU_OP_CEQBI, `SPU_OP_CEQHI, `SPU_OP_CEQI,
				`SPU_OP_CGTBI, `SPU_OP_CGTHI, `SPU_OP_CGTI, `SPU_OP_CLGTBI,
				`SPU_OP_CLGTHI, `SPU_OP_CLGTI}) begin
			fmt = `SPU_FMT_RI10;
			unt = `SPU_UNIT_FX1;
		end else if (word.rr.op inside {`SPU_OP_MPY, `SPU_OP_MPYU, `SPU_OP_MPYH,
				`SPU_OP_FA, `SPU_OP_FS, `SPU_OP_FM, `SPU_OP_FCEQ, `SPU_OP_FCGT,
				`SPU_OP_NOP}) begin
			wr = (word.rr.op != `SPU_OP_NOP);      // nop sits on fp and writes nothing
		end else if (word.rr.op inside {`SPU_OP_SHLH, `SPU_OP_SHL, `SPU_OP_ROTH,
				`SPU_OP_ROT, `SPU_OP_ROTHM, `SPU_OP_ROTM, `SPU_OP_ROTMAH,
				`SPU_OP_ROTMA}) begin
			unt = `SPU_UNIT_FX2;
		end else if (word.rr.op inside {`SPU_OP_CNTB, `SPU_OP_AVGB, `SPU_OP_ABSDB,
				`SPU_OP_SUMB}) begin
			unt = `SPU_UNIT_BYTE;
		end else if (word.rr.op inside {`SPU_OP_AH, `SPU_OP_A, `SPU_OP_SFH, `SPU_OP_SF,
				`SPU_OP_AND, `SPU_OP_OR, `SPU_OP_XOR, `SPU_OP_NAND, `SPU_OP_CEQB,
				`SPU_OP_CEQH, `SPU_OP_CEQ, `SPU_OP_CGTB, `SPU_OP_CGTH, `SPU_OP_CGT,
				`SPU_OP_CLGTB, `SPU_OP_CLGTH, `SPU_OP_CLGT}) begin
			unt = `SPU_UNIT_FX1;
		end else if (word.rr.op inside {`SPU_OP_SHLI, `SPU_OP_ROTHI, `SPU_OP_ROTI,
				`SPU_OP_ROTMAHI, `SPU_OP_ROTMAI}) begin
			fmt = `SPU_FMT_RI7;                    // shift/rotate immediates
			unt = `SPU_UNIT_FX2;
		end else begin
			hit = 1'b0;                            // zero or foreign word
		end
	end

	// a miss leaves every field zero
	assign format = hit ? fmt : '0;
	assign unit = hit ? unt : '0;
	assign op = hit ? op_field(word, fmt) : '0;
	assign imm = hit ? imm_field(word, fmt) : '0;
	assign rt = !hit ? '0 : (fmt == `SPU_FMT_RRR) ? word.rrr.rt : word.rr.rt;
	assign reg_write = hit & wr;

endmodule

`default_nettype wire

/* decode/odd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spu_decode_settings.svh"
`include "spu_opcodes.svh"

module odd_decoder
	import spu_decode_pkg::*;
(
	input  instr_word_u             word,
	output logic                    hit,
	output logic [`SPU_OP_W-1:0]    op,
	output logic [`SPU_FMT_W-1:0]   format,
	output logic [`SPU_UNIT_W-1:0]  unit,
	output logic [`SPU_REG_W-1:0]   rt,
	output logic [`SPU_IMM_W-1:0]   imm,
	output logic                    reg_write
);

	logic [7:0]              p8;    // ri10 prefix
	logic [8:0]              p9;    // ri16 prefix
	logic [`SPU_FMT_W-1:0]   fmt;
	logic [`SPU_UNIT_W-1:0]  unt;
	logic                    wr;

	assign p8 = word.ri[31:24];
	assign p9 = word.ri[31:23];

	always_comb begin
		hit = 1'b1;
		fmt = `SPU_FMT_RR;
		unt = `SPU_UNIT_PERM;
		wr = 1'b1;
		if (p8 inside {`SPU_OP_LQD, `SPU_OP_STQD}) begin
			fmt = `SPU_FMT_RI10;
			unt = `SPU_UNIT_LS;
			wr = (p8 == `SPU_OP_LQD);              // store writes no rt
		end else if (p9 inside {`SPU_OP_LQA, `SPU_OP_STQA}) begin
			fmt = `SPU_FMT_RI16;
			unt = `SPU_UNIT_LS;
			wr = (p9 == `SPU_OP_LQA);
		end else if (p9 inside {`SPU_OP_BR, `SPU_OP_BRA, `SPU_OP_BRSL, `SPU_OP_BRNZ,
				`SPU_OP_BRZ}) begin
			fmt = `SPU_FMT_RI16;
			unt = `SPU_UNIT_BR;
			wr = (p9 == `SPU_OP_BRSL);             // only brsl links
		end else if (word.rr.op inside {`SPU_OP_SHLQBI, `SPU_OP_SHLQBY, `SPU_OP_ROTQBI,
				`SPU_OP_ROTQBY, `SPU_OP_GBB, `SPU_OP_GBH, `SPU_OP_GB, `SPU_OP_LNOP}) begin
			wr = (word.rr.op != `SPU_OP_LNOP);     // lnop parks on perm
		end else if (word.rr.op inside {`SPU_OP_LQX, `SPU_OP_STQX}) begin
			unt = `SPU_UNIT_LS;
			wr = (word.rr.op == `SPU_OP_LQX);
		end else if (word.rr.op == `SPU_OP_BI) begin
			unt = `SPU_UNIT_BR;
			wr = 1'b0;
		end else if (word.rr.op inside {`SPU_OP_SHLQBII, `SPU_OP_SHLQBYI,
				`SPU_OP_ROTQBII, `SPU_OP_ROTQBYI}) begin
			fmt = `SPU_FMT_RI7;
		end else begin
			hit = 1'b0;
		end
	end

	assign format = hit ? fmt : '0;
	assign unit = hit ? unt : '0;
	assign op = hit ? op_field(word, fmt) : '0;
	assign imm = hit ? imm_field(word, fmt) : '0;
	assign rt = hit ? word.rr.rt : '0;       // no rrr on this pipe
	assign reg_write = hit & wr;

endmodule

`default_nettype wire

/* hdl/dual_issue_steer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spu_decode_settings.svh"

module dual_issue_steer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   pair_valid,     // one strobe per fetched pair
	input  logic                   branch_taken,
	input  logic [`SPU_PC_W-1:0]   pc,
	input  logic [`SPU_PC_W-1:0]   branch_pc,
	input  logic                   a_even_hit, a_odd_hit, b_even_hit, b_odd_hit,
	input  logic [`SPU_OP_W-1:0]   a_even_op, a_odd_op, b_even_op, b_odd_op,
	input  logic [`SPU_FMT_W-1:0]  a_even_format, a_odd_format, b_even_format, b_odd_format,
	input  logic [`SPU_UNIT_W-1:0] a_even_unit, a_odd_unit, b_even_unit, b_odd_unit,
	input  logic [`SPU_REG_W-1:0]  a_even_rt, a_odd_rt, b_even_rt, b_odd_rt,
	input  logic [`SPU_IMM_W-1:0]  a_even_imm, a_odd_imm, b_even_imm, b_odd_imm,
	input  logic                   a_even_reg_write, a_odd_reg_write,
	input  logic                   b_even_reg_write, b_odd_reg_write,
	output logic                   even_valid,
	output logic [`SPU_OP_W-1:0]   even_op,
	output logic [`SPU_FMT_W-1:0]  even_format,
	output logic [`SPU_UNIT_W-1:0] even_unit,
	output logic [`SPU_REG_W-1:0]  even_rt,
	output logic [`SPU_IMM_W-1:0]  even_imm,
	output logic                   even_reg_write,
	output logic                   odd_valid,
	output logic [`SPU_OP_W-1:0]   odd_op,
	output logic [`SPU_FMT_W-1:0]  odd_format,
	output logic [`SPU_UNIT_W-1:0] odd_unit,
	output logic [`SPU_REG_W-1:0]  odd_rt,
	output logic [`SPU_IMM_W-1:0]  odd_imm,
	output logic                   odd_reg_write,
	output logic                   first_odd,
	output logic                   stall,
	output logic [`SPU_PC_W-1:0]   stall_pc
);

	localparam int FW = `SPU_OP_W + `SPU_FMT_W + `SPU_UNIT_W + `SPU_REG_W + `SPU_IMM_W + 1;

	logic [FW-1:0] a_e, a_o, b_e, b_o;   // decoded field bundles
	logic [FW-1:0] even_f, odd_f;        // issued slots
	logic [FW-1:0] hold_f;               // deferred second word
	logic          hold_valid;
	logic          hold_odd;             // pipe of the deferred word
	logic          a_fix_e, a_fix_o, b_fix_e, b_fix_o;
	logic          split, swap, a_to_odd;

	assign a_e = {a_even_op, a_even_format, a_even_unit, a_even_rt, a_even_imm, a_even_reg_write};
	assign a_o = {a_odd_op, a_odd_format, a_odd_unit, a_odd_rt, a_odd_imm, a_odd_reg_write};
	assign b_e = {b_even_op, b_even_format, b_even_unit, b_even_rt, b_even_imm, b_even_reg_write};
	assign b_o = {b_odd_op, b_odd_format, b_odd_unit, b_odd_rt, b_odd_imm, b_odd_reg_write};

	// a miss fits either pipe, so only a single-table hit pins a word
	assign a_fix_e = a_even_hit & ~a_odd_hit;
	assign a_fix_o = a_odd_hit & ~a_even_hit;
	assign b_fix_e = b_even_hit & ~b_odd_hit;
	assign b_fix_o = b_odd_hit & ~b_even_hit;
	assign split = (a_fix_e & b_fix_e) | (a_fix_o & b_fix_o);
	assign swap = a_fix_o | b_fix_e;                  // odd-first pair
	assign a_to_odd = split ? a_fix_o : swap;         // slot taken by instr_a

	always_ff @(posedge clk) begin
		if (reset) begin
			even_valid <= 1'b0;
			odd_valid <= 1'b0;
			first_odd <= 1'b0;
			stall <= 1'b0;
			stall_pc <= '0;
			hold_valid <= 1'b0;
		end else begin
			even_valid <= 1'b0;
			odd_valid <= 1'b0;
			first_odd <= 1'b0;
			stall <= 1'b0;
			if (branch_taken) begin
				stall <= 1'b1;                    // flush pair and held word
				stall_pc <= branch_pc;
				hold_valid <= 1'b0;
			end else if (hold_valid) begin
				even_valid <= ~hold_odd;          // second half of a split
				odd_valid <= hold_odd;
				hold_valid <= 1'b0;
			end else if (pair_valid && split) begin
				even_valid <= ~a_to_odd;
				odd_valid <= a_to_odd;
				hold_valid <= 1'b1;
				stall <= 1'b1;
				stall_pc <= pc;
			end else if (pair_valid) begin
				even_valid <= 1'b1;
				odd_valid <= 1'b1;
				first_odd <= swap;
			end
		end
	end

	// payload path, qualified by the valids above
	always_ff @(posedge clk) begin
		even_f <= hold_valid ? hold_f : (a_to_odd ? b_e : a_e);
		odd_f <= hold_valid ? hold_f : (a_to_odd ? a_o : b_o);
		if (pair_valid && split && !hold_valid && !branch_taken) begin
			hold_f <= a_fix_o ? b_o : b_e;
			hold_odd <= a_fix_o;
		end
	end

	assign {even_op, even_format, even_unit, even_rt, even_imm, even_reg_write} = even_f;
	assign {odd_op, odd_format, odd_unit, odd_rt, odd_imm, odd_reg_write} = odd_f;

endmodule

`default_nettype wire

/* hdl/spu_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spu_decode_settings.svh"

module spu_decode
	import spu_decode_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`SPU_INSTR_W-1:0] instr_a,       // first in program order
	input  logic [`SPU_INSTR_W-1:0] instr_b,
	input  logic [`SPU_PC_W-1:0]   pc,
	input  logic                   pair_valid,
	input  logic                   branch_taken,
	input  logic [`SPU_PC_W-1:0]   branch_pc,
	output logic                   even_valid,
	output logic [`SPU_OP_W-1:0]   even_op,
	output logic [`SPU_FMT_W-1:0]  even_format,
	output logic [`SPU_UNIT_W-1:0] even_unit,
	output logic [`SPU_REG_W-1:0]  even_rt,
	output logic [`SPU_IMM_W-1:0]  even_imm,
	output logic                   even_reg_write,
	output logic                   odd_valid,
	output logic [`SPU_OP_W-1:0]   odd_op,
	output logic [`SPU_FMT_W-1:0]  odd_format,
	output logic [`SPU_UNIT_W-1:0] odd_unit,
	output logic [`SPU_REG_W-1:0]  odd_rt,
	output logic [`SPU_IMM_W-1:0]  odd_imm,
	output logic                   odd_reg_write,
	output logic                   first_odd,
	output logic                   stall,
	output logic [`SPU_PC_W-1:0]   stall_pc
);

	instr_word_u             word_a, word_b;
	logic                    a_even_hit, a_odd_hit, b_even_hit, b_odd_hit;
	logic [`SPU_OP_W-1:0]    a_even_op, a_odd_op, b_even_op, b_odd_op;
	logic [`SPU_FMT_W-1:0]   a_even_format, a_odd_format, b_even_format, b_odd_format;
	logic [`SPU_UNIT_W-1:0]  a_even_unit, a_odd_unit, b_even_unit, b_odd_unit;
	logic [`SPU_REG_W-1:0]   a_even_rt, a_odd_rt, b_even_rt, b_odd_rt;
	logic [`SPU_IMM_W-1:0]   a_even_imm, a_odd_imm, b_even_imm, b_odd_imm;
	logic                    a_even_reg_write, a_odd_reg_write, b_even_reg_write, b_odd_reg_write;

	assign word_a = instr_a;    // view raw words through the format union
	assign word_b = instr_b;

	// each word tried against both pipe tables
	even_decoder a_even_i (.word(word_a), .hit(a_even_hit), .op(a_even_op),
		.format(a_even_format), .unit(a_even_unit), .rt(a_even_rt), .imm(a_even_imm),
		.reg_write(a_even_reg_write));
	odd_decoder a_odd_i (.word(word_a), .hit(a_odd_hit), .op(a_odd_op),
		.format(a_odd_format), .unit(a_odd_unit), .rt(a_odd_rt), .imm(a_odd_imm),
		.reg_write(a_odd_reg_write));
	even_decoder b_even_i (.word(word_b), .hit(b_even_hit), .op(b_even_op),
		.format(b_even_format), .unit(b_even_unit), .rt(b_even_rt), .imm(b_even_imm),
		.reg_write(b_even_reg_write));
	odd_decoder b_odd_i (.word(word_b), .hit(b_odd_hit), .op(b_odd_op),
		.format(b_odd_format), .unit(b_odd_unit), .rt(b_odd_rt), .imm(b_odd_imm),
		.reg_write(b_odd_reg_write));

	dual_issue_steer steer_i (.*);   // names match one to one

endmodule

`default_nettype wire

/* tb/spu_decode_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "spu_decode_settings.svh"
`include "spu_opcodes.svh"

module spu_decode_tb;

	localparam int NROWS = 22;
	localparam int TIMEOUT = 20;        // falling edges allowed per wait
	localparam int EVEN = 0;
	localparam int ODD = 1;
	localparam int EITHER = 2;          // miss in both tables

	logic                    clk;
	logic                    reset;
	logic [`SPU_INSTR_W-1:0] instr_a, instr_b;
	logic [`SPU_PC_W-1:0]    pc, branch_pc;
	logic                    pair_valid, branch_taken;
	logic                    even_valid, odd_valid, first_odd, stall;
	logic [`SPU_OP_W-1:0]    even_op, odd_op;
	logic [`SPU_FMT_W-1:0]   even_format, odd_format;
	logic [`SPU_UNIT_W-1:0]  even_unit, odd_unit;
	logic [`SPU_REG_W-1:0]   even_rt, odd_rt;
	logic [`SPU_IMM_W-1:0]   even_imm, odd_imm;
	logic                    even_reg_write, odd_reg_write;
	logic [`SPU_PC_W-1:0]    stall_pc;

	logic [`SPU_OP_W-1:0]    t_op [NROWS];      // right-aligned opcode
	int                      t_pipe [NROWS];
	logic [`SPU_FMT_W-1:0]   t_fmt [NROWS];
	logic [`SPU_UNIT_W-1:0]  t_unit [NROWS];
	logic                    t_wr [NROWS];
	int                      t_rt_lsb [NROWS];  // lowest bit of rt

	logic [`SPU_INSTR_W-1:0] w_word [2];        // index 0 is instr_a
	logic [`SPU_OP_W-1:0]    w_op [2];
	logic [`SPU_FMT_W-1:0]   w_fmt [2];
	logic [`SPU_UNIT_W-1:0]  w_unit [2];
	logic [`SPU_REG_W-1:0]   w_rt [2];
	logic [`SPU_IMM_W-1:0]   w_imm [2];
	logic                    w_wr [2];
	int                      w_pipe [2];

	int                      exp_e_src, exp_o_src;   // word feeding each slot or -1
	logic                    exp_fo, exp_st;
	logic [`SPU_PC_W-1:0]    exp_spc;
	int                      mismatch_count, fail_count;
	integer                  seed;
	int                      i, j;

	spu_decode dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;          // 10 ns period
	end

	task automatic set_row(input int idx, input logic [10:0] op, input int pipe,
			input logic [2:0] fmt, input logic [1:0] unit, input logic wr, input int rt_lsb);
		t_op[idx] = op;
		t_pipe[idx] = pipe;
		t_fmt[idx] = fmt;
		t_unit[idx] = unit;
		t_wr[idx] = wr;
		t_rt_lsb[idx] = rt_lsb;
	endtask

	task automatic fill_table();
		set_row(0, `SPU_OP_MPYA, EVEN, `SPU_FMT_RRR, `SPU_UNIT_FP, 1, 21);
		set_row(1, `SPU_OP_FMS, EVEN, `SPU_FMT_RRR, `SPU_UNIT_FP, 1, 21);
		set_row(2, `SPU_OP_ILA, EVEN, `SPU_FMT_RI18, `SPU_UNIT_FX1, 1, 0);
		set_row(3, `SPU_OP_CFLTS, EVEN, `SPU_FMT_RI8, `SPU_UNIT_FP, 1, 0);
		set_row(4, `SPU_OP_ILH, EVEN, `SPU_FMT_RI16, `SPU_UNIT_FX1, 1, 0);
		set_row(5, `SPU_OP_MPYI, EVEN, `SPU_FMT_RI10, `SPU_UNIT_FP, 1, 0);
		set_row(6, `SPU_OP_AI, EVEN, `SPU_FMT_RI10, `SPU_UNIT_FX1, 1, 0);
		set_row(7, `SPU_OP_FA, EVEN, `SPU_FMT_RR, `SPU_UNIT_FP, 1, 0);
		set_row(8, `SPU_OP_SHL, EVEN, `SPU_FMT_RR, `SPU_UNIT_FX2, 1, 0);
		set_row(9, `SPU_OP_CNTB, EVEN, `SPU_FMT_RR, `SPU_UNIT_BYTE, 1, 0);
		set_row(10, `SPU_OP_AND, EVEN, `SPU_FMT_RR, `SPU_UNIT_FX1, 1, 0);
		set_row(11, `SPU_OP_NOP, EVEN, `SPU_FMT_RR, `SPU_UNIT_FP, 0, 0);
		set_row(12, `SPU_OP_SHLI, EVEN, `SPU_FMT_RI7, `SPU_UNIT_FX2, 1, 0);
		set_row(13, `SPU_OP_LQD, ODD, `SPU_FMT_RI10, `SPU_UNIT_LS, 1, 0);
		set_row(14, `SPU_OP_STQD, ODD, `SPU_FMT_RI10, `SPU_UNIT_LS, 0, 0);
		set_row(15, `SPU_OP_LQA, ODD, `SPU_FMT_RI16, `SPU_UNIT_LS, 1, 0);
		set_row(16, `SPU_OP_BRSL, ODD, `SPU_FMT_RI16, `SPU_UNIT_BR, 1, 0);
		set_row(17, `SPU_OP_BR, ODD, `SPU_FMT_RI16, `SPU_UNIT_BR, 0, 0);
		set_row(18, `SPU_OP_ROTQBY, ODD, `SPU_FMT_RR, `SPU_UNIT_PERM, 1, 0);
		set_row(19, `SPU_OP_LNOP, ODD, `SPU_FMT_RR, `SPU_UNIT_PERM, 0, 0);
		set_row(20, `SPU_OP_STQX, ODD, `SPU_FMT_RR, `SPU_UNIT_LS, 0, 0);
		set_row(21, `SPU_OP_ROTQBII, ODD, `SPU_FMT_RI7, `SPU_UNIT_PERM, 1, 0);
	endtask

	// one word with random operands where row -1 gives a zero word and -2 a foreign one
	task automatic make_word(input int s, input int row);
		logic [31:0] r1, r2;
		logic [6:0]  rt_v, ra, rb, rc;
		logic [17:0] iv;
		r1 = $random(seed);
		r2 = $random(seed);
		rt_v = r1[6:0];
		ra = r1[13:7];
		rb = r1[20:14];
		rc = r1[27:21];
		iv = r2[17:0];
		w_op[s] = '0;                   // misses expect all fields zero
		w_fmt[s] = '0;
		w_unit[s] = '0;
		w_rt[s] = '0;
		w_imm[s] = '0;
		w_wr[s] = 1'b0;
		w_pipe[s] = EITHER;
		if (row == -1) begin
			w_word[s] = '0;
		end else if (row == -2) begin
			w_word[s] = {11'b10000000000, r1[20:0]};    // no opcode starts with 1000
		end else begin
			case (t_fmt[row])
				`SPU_FMT_RRR: w_word[s] = {t_op[row][3:0], rt_v, rb, ra, rc};
				`SPU_FMT_RI18: begin
					w_word[s] = {t_op[row][6:0], iv, rt_v};
					w_imm[s] = iv;
				end
				`SPU_FMT_RI16: begin
					w_word[s] = {t_op[row][8:0], iv[15:0], rt_v};
					w_imm[s] = {{2{iv[15]}}, iv[15:0]};
				end
				`SPU_FMT_RI10: begin
					w_word[s] = {t_op[row][7:0], iv[9:0], ra, rt_v};
					w_imm[s] = {{8{iv[9]}}, iv[9:0]};
				end
				`SPU_FMT_RI8: begin
					w_word[s] = {t_op[row][9:0], iv[7:0], ra, rt_v};
					w_imm[s] = {{10{iv[7]}}, iv[7:0]};
				end
				`SPU_FMT_RI7: begin
					w_word[s] = {t_op[row], iv[6:0], ra, rt_v};
					w_imm[s] = {{11{iv[6]}}, iv[6:0]};
				end
				default: w_word[s] = {t_op[row], rb, ra, rt_v};
			endcase
			w_rt[s] = w_word[s][t_rt_lsb[row] +: 7];     // rt where the row places it
			w_op[s] = t_op[row];
			w_fmt[s] = t_fmt[row];
			w_unit[s] = t_unit[row];
			w_wr[s] = t_wr[row];
			w_pipe[s] = t_pipe[row];
		end
	endtask

	// expected slots for a fresh pair
	task automatic predict_pair(input logic [`SPU_PC_W-1:0] pcv);
		logic a_odd;
		exp_st = 1'b0;
		exp_fo = 1'b0;
		if (w_pipe[0] != EITHER && w_pipe[0] == w_pipe[1]) begin
			exp_st = 1'b1;              // same pipe so instr_a goes alone
			exp_spc = pcv;
			exp_e_src = (w_pipe[0] == EVEN) ? 0 : -1;
			exp_o_src = (w_pipe[0] == ODD) ? 0 : -1;
		end else begin
			a_odd = (w_pipe[0] == ODD) || (w_pipe[1] == EVEN);
			exp_fo = a_odd;
			exp_e_src = a_odd ? 1 : 0;
			exp_o_src = a_odd ? 0 : 1;
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, want);
			mismatch_count++;
		end
	endtask

	task automatic check_outputs();
		check_val("even_valid", even_valid, exp_e_src >= 0);
		check_val("odd_valid", odd_valid, exp_o_src >= 0);
		check_val("first_odd", first_odd, exp_fo);
		check_val("stall", stall, exp_st);
		if (exp_st)
			check_val("stall_pc", stall_pc, exp_spc);
		if (exp_e_src >= 0) begin
			check_val("even_op", even_op, w_op[exp_e_src]);
			check_val("even_format", even_format, w_fmt[exp_e_src]);
			check_val("even_unit", even_unit, w_unit[exp_e_src]);
			check_val("even_rt", even_rt, w_rt[exp_e_src]);
			check_val("even_imm", even_imm, w_imm[exp_e_src]);
			check_val("even_reg_write", even_reg_write, w_wr[exp_e_src]);
		end
		if (exp_o_src >= 0) begin
			check_val("odd_op", odd_op, w_op[exp_o_src]);
			check_val("odd_format", odd_format, w_fmt[exp_o_src]);
			check_val("odd_unit", odd_unit, w_unit[exp_o_src]);
			check_val("odd_rt", odd_rt, w_rt[exp_o_src]);
			check_val("odd_imm", odd_imm, w_imm[exp_o_src]);
			check_val("odd_reg_write", odd_reg_write, w_wr[exp_o_src]);
		end
	endtask

	// result is due at this falling edge and a late one still gets reported
	task automatic wait_for_issue();
		int n;
		n = 0;
		while (!(even_valid || odd_valid || stall) && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!(even_valid || odd_valid || stall)) begin
			$display("timeout: no slot issued and no stall within %0d cycles", TIMEOUT);
			fail_count++;
		end else if (n != 0) begin
			$display("late result: slots appeared %0d cycles after the expected cycle", n);
			fail_count++;
		end
	endtask

	task automatic strobe_pair(input int row_a, input int row_b);
		logic [`SPU_PC_W-1:0] pcv;
		pcv = $random(seed);
		make_word(0, row_a);
		make_word(1, row_b);
		@(negedge clk);
		instr_a = w_word[0];
		instr_b = w_word[1];
		pc = pcv;
		pair_valid = 1'b1;
		@(negedge clk);
		pair_valid = 1'b0;              // one-cycle strobe
		predict_pair(pcv);
		wait_for_issue();
		check_outputs();
	endtask

	// same-pipe pair followed by the held instr_b
	task automatic split_pair(input int row_a, input int row_b);
		strobe_pair(row_a, row_b);
		@(negedge clk);
		exp_st = 1'b0;
		exp_fo = 1'b0;
		exp_e_src = (w_pipe[1] == EVEN) ? 1 : -1;
		exp_o_src = (w_pipe[1] == ODD) ? 1 : -1;
		wait_for_issue();
		check_outputs();
	endtask

	task automatic flush_hold(input int row_a, input int row_b);
		logic [`SPU_PC_W-1:0] target;
		target = $random(seed);
		strobe_pair(row_a, row_b);      // now in the stall cycle
		branch_taken = 1'b1;
		branch_pc = target;
		@(negedge clk);
		branch_taken = 1'b0;
		exp_e_src = -1;
		exp_o_src = -1;
		exp_fo = 1'b0;
		exp_st = 1'b1;
		exp_spc = target;
		wait_for_issue();
		check_outputs();
		exp_st = 1'b0;
		repeat (3) begin
			@(negedge clk);             // held word must stay gone
			check_outputs();
		end
	endtask

	initial begin
		seed = 4349;
		mismatch_count = 0;
		fail_count = 0;
		reset = 1'b1;
		instr_a = '0;
		instr_b = '0;
		pc = '0;
		pair_valid = 1'b0;
		branch_taken = 1'b0;
		branch_pc = '0;
		fill_table();
		repeat (4) @(negedge clk);
		exp_e_src = -1;                 // quiet while in reset
		exp_o_src = -1;
		exp_fo = 1'b0;
		exp_st = 1'b0;
		check_outputs();
		check_val("stall_pc", stall_pc, 0);
		reset = 1'b0;
		for (i = 0; i < NROWS; i++) begin
			j = (i + 1) % NROWS;
			while (t_pipe[j] == t_pipe[i])
				j = (j + 1) % NROWS;    // partner from the other pipe
			strobe_pair(i, j);
		end
		split_pair(7, 2);               // fa, ila
		split_pair(13, 17);             // lqd, br
		split_pair(14, 13);             // stqd, lqd
		strobe_pair(-2, 13);
		strobe_pair(16, -1);
		strobe_pair(-1, -2);
		strobe_pair(-1, 9);
		flush_hold(8, 5);
		flush_hold(15, 20);
		$display("decode checks finished: %0d mismatches, %0d other failures",
			mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/spu_decode_pkg.sv
decode/even_decoder.sv
decode/odd_decoder.sv
hdl/dual_issue_steer.sv
hdl/spu_decode.sv
tb/spu_decode_tb.sv

/* Bender.yml */
package:
  name: spu_decode

export_include_dirs:
  - common

sources:
  - files:
      - common/spu_decode_pkg.sv
      - decode/even_decoder.sv
      - decode/odd_decoder.sv
      - hdl/dual_issue_steer.sv
      - hdl/spu_decode.sv
  - target: test
    files:
      - tb/spu_decode_tb.sv
